/* ffe_adapt.f */
ffe_adapt_pkg.sv
sample_history.sv
ffe_filter.sv
ffe_estimator.sv
ffe_adapt_top.sv
tb_ffe_adapt.sv

/* ffe_adapt_pkg.sv */
package ffe_adapt_pkg;

    // Raw ADC code from the front end.
    localparam int code_w = 8;

    // Equalized sample at the FIR output.
    localparam int est_w = 10;

    // Integer part of one FFE tap.
    localparam int tap_w = 10;

    // Fraction bits kept below each tap inside the accumulator.
    localparam int adapt_w = 14;

    // The adaptation gain is a left shift of at most adapt_w - 1 places.
    localparam int gain_w = $clog2(adapt_w);

    typedef logic signed [code_w-1:0] code_t;
    typedef logic signed [est_w-1:0] est_t;
    typedef logic signed [tap_w-1:0] tap_t;
    typedef logic signed [tap_w+adapt_w-1:0] acc_t;

    // Slicer setup. The thresholds must be ordered lo < mid < hi.
    typedef struct packed {
        est_t bit_target_level;
        est_t slice_lo;
        est_t slice_mid;
        est_t slice_hi;
    } slicer_cfg_t;

    // One instruction for the estimator. It runs once while exec is high.
    typedef struct packed {
        logic       exec;
        logic [2:0] inst;
    } adapt_cmd_t;

    // Instruction encodings. Any other value is a no-operation.
    localparam logic [2:0] inst_load_init   = 3'd4;
    localparam logic [2:0] inst_shift_left  = 3'd3;
    localparam logic [2:0] inst_shift_right = 3'd2;

endpackage : ffe_adapt_pkg

/* ffe_adapt_top.sv */
`timescale 1ns/10ps

module ffe_adapt_top #(
    parameter int est_depth = 10,
    parameter int out_shift = 6
) (
    input  logic                             clk,
    input  logic                             rst_n,

    input  ffe_adapt_pkg::code_t             code_in,
    input  logic                             code_valid,

    input  ffe_adapt_pkg::tap_t              ffe_init [est_depth-1:0],
    input  ffe_adapt_pkg::slicer_cfg_t       slicer_cfg,
    input  logic [ffe_adapt_pkg::gain_w-1:0] gain,
    input  logic                             nrz_mode,
    input  ffe_adapt_pkg::adapt_cmd_t        cmd,

    output ffe_adapt_pkg::est_t              eq_out,
    output logic                             eq_valid,
    output ffe_adapt_pkg::tap_t              ffe_est  [est_depth-1:0]
);

    ffe_adapt_pkg::code_t code_window [est_depth-1:0];
    ffe_adapt_pkg::est_t  est_bits    [est_depth-1:0];

    sample_history #(
        .payload_t (ffe_adapt_pkg::code_t),
        .depth     (est_depth)
    ) code_history (
        .clk      (clk),
        .rst_n    (rst_n),
        .in       (code_in),
        .in_valid (code_valid),
        .window   (code_window)
    );

    ffe_filter #(
        .depth     (est_depth),
        .out_shift (out_shift)
    ) u_filter (
        .clk        (clk),
        .rst_n      (rst_n),
        .codes      (code_window),
        .code_valid (code_valid),
        .taps       (ffe_est),
        .eq_out     (eq_out),
        .eq_valid   (eq_valid)
    );

    sample_history #(
        .payload_t (ffe_adapt_pkg::est_t),
        .depth     (est_depth)
    ) eq_history (
        .clk      (clk),
        .rst_n    (rst_n),
        .in       (eq_out),
        .in_valid (eq_valid),
        .window   (est_bits)
    );

    // The centre of the code window is the main cursor.
    ffe_estimator #(
        .est_depth (est_depth)
    ) u_estimator (
        .clk          (clk),
        .rst_n        (rst_n),
        .est_bits     (est_bits),
        .current_code (code_window[est_depth/2]),
        .gain         (gain),
        .slicer_cfg   (slicer_cfg),
        .nrz_mode     (nrz_mode),
        .cmd          (cmd),
        .ffe_init     (ffe_init),
        .ffe_est      (ffe_est)
    );

endmodule : ffe_adapt_top

/* ffe_estimator.sv */
`timescale 1ns/10ps

module ffe_estimator #(
    parameter int est_depth = 10
) (
    input  logic                             clk,
    input  logic                             rst_n,

    input  ffe_adapt_pkg::est_t              est_bits [est_depth-1:0],
    input  ffe_adapt_pkg::code_t             current_code,

    input  logic [ffe_adapt_pkg::gain_w-1:0] gain,
    input  ffe_adapt_pkg::slicer_cfg_t       slicer_cfg,
    input  logic                             nrz_mode,

    input  ffe_adapt_pkg::adapt_cmd_t        cmd,

    input  ffe_adapt_pkg::tap_t              ffe_init [est_depth-1:0],
    output ffe_adapt_pkg::tap_t              ffe_est  [est_depth-1:0]
);

    localparam int pos_w = (est_depth > 1) ? $clog2(est_depth) : 1;

    typedef enum logic [2:0] {
        s_reset,
        s_load_calc,
        s_calc_store,
        s_exec,
        s_halt
    } est_state_t;

    est_state_t state, next_state;

    logic [pos_w-1:0]    tap_pos, next_tap_pos;
    ffe_adapt_pkg::acc_t tap_sum, next_tap_sum;
    ffe_adapt_pkg::acc_t acc [est_depth-1:0];

    logic store_tap;
    logic load_init;
    logic shift_left;
    logic shift_right;

    ffe_adapt_pkg::est_t sample;
    logic [2:0]          therm;
    logic [1:0]          sym_idx;
    logic                inner_sym;
    ffe_adapt_pkg::acc_t level_one;
    ffe_adapt_pkg::acc_t level_three;
    ffe_adapt_pkg::acc_t sym_level;
    ffe_adapt_pkg::acc_t diff;
    ffe_adapt_pkg::acc_t err;
    ffe_adapt_pkg::acc_t adjust;

    // Slicer, balance-weighted error and the scaled adjustment for the current tap.
    always_comb begin
        sample = est_bits[tap_pos];

        therm[0] = sample > slicer_cfg.slice_lo;
        therm[1] = sample > slicer_cfg.slice_mid;
        therm[2] = sample > slicer_cfg.slice_hi;

        // NRZ only uses the two outer symbols, decided on the middle threshold.
        if (nrz_mode) begin
            sym_idx = therm[1] ? 2'd3 : 2'd0;
        end else begin
            sym_idx = 2'(therm[0]) + 2'(therm[1]) + 2'(therm[2]);
        end

        level_one   = ffe_adapt_pkg::acc_t'(slicer_cfg.bit_target_level);
        level_three = level_one + (level_one <<< 1);

        case (sym_idx)
            2'd0:    sym_level = -level_three;
            2'd1:    sym_level = -level_one;
            2'd2:    sym_level = level_one;
            default: sym_level = level_three;
        endcase

        // Inner symbols are rarer in the error, so they get three times the weight.
        inner_sym = (sym_idx == 2'd1) || (sym_idx == 2'd2);
        diff      = sym_level - ffe_adapt_pkg::acc_t'(sample);
        err       = inner_sym ? (diff + (diff <<< 1)) : diff;

        adjust = (ffe_adapt_pkg::acc_t'(current_code) * err) <<< gain;
    end

    always_comb begin
        for (int i = 0; i < est_depth; i++) begin
            ffe_est[i] = ffe_adapt_pkg::tap_t'(acc[i] >>> ffe_adapt_pkg::adapt_w);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= s_reset;
            tap_pos <= '0;
            tap_sum <= '0;
            for (int i = 0; i < est_depth; i++) begin
                acc[i] <= '0;
            end
        end else begin
            state   <= next_state;
            tap_pos <= next_tap_pos;
            tap_sum <= next_tap_sum;
            if (store_tap) begin
                acc[tap_pos] <= next_tap_sum;
            end
            if (load_init) begin
                for (int i = 0; i < est_depth; i++) begin
                    acc[i] <= ffe_adapt_pkg::acc_t'(ffe_init[i]) <<< ffe_adapt_pkg::adapt_w;
                end
            end
            if (shift_left) begin
                for (int i = 1; i < est_depth; i++) begin
                    acc[i-1] <= acc[i];
                end
                acc[est_depth-1] <= '0;
            end
            if (shift_right) begin
                for (int i = est_depth - 1; i > 0; i--) begin
                    acc[i] <= acc[i-1];
                end
                acc[0] <= '0;
            end
        end
    end

    // Two cycles per tap. The adjustment is added once on load and once on store.
    always_comb begin
        next_state   = state;
        next_tap_pos = '0;
        next_tap_sum = '0;
        case (state)
            s_reset: begin
                next_state = cmd.exec ? s_exec : s_load_calc;
            end
            s_load_calc: begin
                next_state   = cmd.exec ? s_exec : s_calc_store;
                next_tap_pos = tap_pos;
                next_tap_sum = acc[tap_pos] + adjust;
            end
            s_calc_store: begin
                next_state   = s_load_calc;
                next_tap_sum = tap_sum + adjust;
                if (tap_pos != pos_w'(est_depth - 1)) begin
                    next_tap_pos = tap_pos + 1'b1;
                end
            end
            s_exec: begin
                next_state = s_halt;
            end
            s_halt: begin
                next_state = cmd.exec ? s_halt : s_load_calc;
            end
            default: begin
                next_state = s_reset;
            end
        endcase
    end

    always_comb begin
        store_tap   = (state == s_calc_store);
        load_init   = 1'b0;
        shift_left  = 1'b0;
        shift_right = 1'b0;
        if (state == s_exec) begin
            case (cmd.inst)
                ffe_adapt_pkg::inst_load_init:   load_init   = 1'b1;
                ffe_adapt_pkg::inst_shift_left:  shift_left  = 1'b1;
                ffe_adapt_pkg::inst_shift_right: shift_right = 1'b1;
                default: ;
            endcase
        end
    end

    a_state_legal : assert property (
        @(posedge clk) disable iff (!rst_n)
        state inside {s_reset, s_load_calc, s_calc_store, s_exec, s_halt}
    ) else $error("ffe_estimator: illegal state encoding %0h", state);

    // The symbol decision is only meaningful with ordered thresholds while sweeping.
    a_thresholds_ordered : assert property (
        @(posedge clk) disable iff (!rst_n)
        (state inside {s_load_calc, s_calc_store}) |->
            (slicer_cfg.slice_lo < slicer_cfg.slice_mid) &&
            (slicer_cfg.slice_mid < slicer_cfg.slice_hi)
    ) else $error("ffe_estimator: slicer thresholds out of order");

endmodule : ffe_estimator

/* ffe_filter.sv */
`timescale 1ns/10ps

module ffe_filter #(
    parameter int depth     = 10,
    parameter int out_shift = 6
) (
    input  logic                clk,
    input  logic                rst_n,

    input  ffe_adapt_pkg::code_t codes [depth-1:0],
    input  logic                code_valid,
    input  ffe_adapt_pkg::tap_t  taps  [depth-1:0],

    output ffe_adapt_pkg::est_t  eq_out,
    output logic                eq_valid
);

    // One product is code_w + tap_w bits; the sum grows by log2 of the depth.
    localparam int prod_w = ffe_adapt_pkg::code_w + ffe_adapt_pkg::tap_w;
    localparam int sum_w  = prod_w + $clog2(depth) + 1;

    localparam ffe_adapt_pkg::est_t est_max = {1'b0, {(ffe_adapt_pkg::est_w-1){1'b1}}};
    localparam ffe_adapt_pkg::est_t est_min = {1'b1, {(ffe_adapt_pkg::est_w-1){1'b0}}};

    logic signed [sum_w-1:0] fir_sum;
    logic signed [sum_w-1:0] fir_scaled;
    ffe_adapt_pkg::est_t     fir_sat;

    always_comb begin
        fir_sum = '0;
        for (int i = 0; i < depth; i++) begin
            fir_sum = fir_sum + codes[i] * taps[i];
        end

        fir_scaled = fir_sum >>> out_shift;

        // Clip to the signed range of one equalized sample.
        if (fir_scaled > est_max) begin
            fir_sat = est_max;
        end else if (fir_scaled < est_min) begin
            fir_sat = est_min;
        end else begin
            fir_sat = ffe_adapt_pkg::est_t'(fir_scaled);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            eq_valid <= 1'b0;
        end else begin
            eq_valid <= code_valid;
        end
    end

    // The sample only moves on a new code, so the output holds between strobes.
    always_ff @(posedge clk) begin
        if (code_valid) begin
            eq_out <= fir_sat;
        end
    end

    // An unknown sample would spread through the history into every tap update.
    a_eq_out_known : assert property (
        @(posedge clk) disable iff (!rst_n)
        eq_valid |-> !$isunknown(eq_out)
    ) else $error("ffe_filter: eq_out is unknown while eq_valid is high");

endmodule : ffe_filter

/* sample_history.sv */
`timescale 1ns/10ps

module sample_history #(
    parameter type payload_t = logic [7:0],
    parameter int  depth     = 10
) (
    input  logic     clk,
    input  logic     rst_n,

    input  payload_t in,
    input  logic     in_valid,

    output payload_t window [depth-1:0]
);

    // Index 0 holds the newest payload and index depth-1 the oldest.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < depth; i++) begin
                window[i] <= '0;
            end
        end else if (in_valid) begin
            for (int i = depth - 1; i > 0; i--) begin
                window[i] <= window[i-1];
            end
            window[0] <= in;
        end
    end

    // An unknown strobe would corrupt the whole window for depth samples.
    a_in_valid_known : assert property (
        @(posedge clk) disable iff (!rst_n)
        !$isunknown(in_valid)
    ) else $error("sample_history: in_valid is unknown");

endmodule : sample_history

/* tb_ffe_adapt.sv */
`timescale 1ns/10ps

module tb_ffe_adapt;

    localparam int est_depth    = 10;
    localparam int out_shift    = 6;
    localparam int clk_period   = 20;
    localparam int reset_cycles = 16;

    localparam int stream_len    = 40;
    localparam int drain_limit   = 8;
    localparam int cmd_cycles    = 4;
    localparam int sweep_cycles  = 2 * est_depth + 4;
    localparam int stream_cycles = stream_len + drain_limit + 2;
    localparam int test_cycles   = (3 + stream_cycles) + (cmd_cycles + stream_cycles)
                                 + (2 * cmd_cycles + stream_cycles) + (cmd_cycles + sweep_cycles)
                                 + (cmd_cycles + 2 * est_depth + drain_limit + 2 + sweep_cycles);
    localparam int watchdog_cycles = reset_cycles + 2 * test_cycles + 100;

    localparam longint est_hi = 2 ** (ffe_adapt_pkg::est_w - 1) - 1;
    localparam longint est_lo = -(2 ** (ffe_adapt_pkg::est_w - 1));

    logic                             clk;
    logic                             rst_n;
    ffe_adapt_pkg::code_t             code_in;
    logic                             code_valid;
    ffe_adapt_pkg::tap_t              ffe_init [est_depth-1:0];
    ffe_adapt_pkg::slicer_cfg_t       slicer_cfg;
    logic [ffe_adapt_pkg::gain_w-1:0] gain;
    logic                             nrz_mode;
    ffe_adapt_pkg::adapt_cmd_t        cmd;
    ffe_adapt_pkg::est_t              eq_out;
    logic                             eq_valid;
    ffe_adapt_pkg::tap_t              ffe_est  [est_depth-1:0];

    // Models of both history windows and of the accumulators. Index 0 is the newest.
    ffe_adapt_pkg::code_t code_model [est_depth];
    ffe_adapt_pkg::est_t  eq_model   [est_depth];
    ffe_adapt_pkg::acc_t  acc_model  [est_depth];
    ffe_adapt_pkg::est_t  exp_q [$];

    integer seed = 32'h09fa_3360;
    int     err_count = 0;
    int     n_checks  = 0;
    int     n_passed  = 0;
    int     n_failed  = 0;
    int     mark;

    ffe_adapt_top #(
        .est_depth (est_depth),
        .out_shift (out_shift)
    ) uut (
        .clk        (clk),
        .rst_n      (rst_n),
        .code_in    (code_in),
        .code_valid (code_valid),
        .ffe_init   (ffe_init),
        .slicer_cfg (slicer_cfg),
        .gain       (gain),
        .nrz_mode   (nrz_mode),
        .cmd        (cmd),
        .eq_out     (eq_out),
        .eq_valid   (eq_valid),
        .ffe_est    (ffe_est)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    function automatic ffe_adapt_pkg::tap_t tap_of(int i);
        return ffe_adapt_pkg::tap_t'(acc_model[i] >>> ffe_adapt_pkg::adapt_w);
    endfunction

    function automatic ffe_adapt_pkg::est_t fir_ref();
        longint sum;
        longint scaled;
        sum = 0;
        for (int i = 0; i < est_depth; i++) begin
            sum += longint'(code_model[i]) * longint'(tap_of(i));
        end
        scaled = sum >>> out_shift;
        if (scaled > est_hi) scaled = est_hi;
        if (scaled < est_lo) scaled = est_lo;
        return ffe_adapt_pkg::est_t'(scaled);
    endfunction

    // The symbol index runs from 0 to 3 and counts up from the lowest level.
    function automatic int slice_symbol(ffe_adapt_pkg::est_t s);
        int sym;
        sym = 0;
        if (nrz_mode) begin
            return (s > slicer_cfg.slice_mid) ? 3 : 0;
        end
        if (s > slicer_cfg.slice_lo) sym++;
        if (s > slicer_cfg.slice_mid) sym++;
        if (s > slicer_cfg.slice_hi) sym++;
        return sym;
    endfunction

    function automatic longint weighted_error(ffe_adapt_pkg::est_t s);
        int     sym;
        longint level;
        sym   = slice_symbol(s);
        level = longint'(2 * sym - 3) * longint'(slicer_cfg.bit_target_level);
        if (sym == 1 || sym == 2) begin
            return 3 * (level - longint'(s));
        end
        return level - longint'(s);
    endfunction

    function automatic ffe_adapt_pkg::acc_t tap_adjust(int pos);
        longint prod;
        prod = longint'(code_model[est_depth/2]) * weighted_error(eq_model[pos]);
        return ffe_adapt_pkg::acc_t'(prod <<< gain);
    endfunction

    // Checks every equalized sample against the queue of expected values.
    initial begin
        ffe_adapt_pkg::est_t exp;
        forever begin
            @(negedge clk);
            if (rst_n && eq_valid === 1'b1) begin
                if (exp_q.size() == 0) begin
                    $display("eq_valid pulsed with no code pending");
                    err_count++;
                end else begin
                    exp = exp_q.pop_front();
                    n_checks++;
                    assert (eq_out === exp) else begin
                        $display("[FAIL] eq_out: expected %h, got %h", exp, eq_out);
                        err_count++;
                    end
                end
            end
        end
    end

    task automatic wait_drain();
        for (int i = 0; i < drain_limit; i++) begin
            if (exp_q.size() == 0) break;
            @(negedge clk);
        end
        if (exp_q.size() != 0) begin
            $display("eq_valid never came for %0d codes", exp_q.size());
            err_count++;
            exp_q.delete();
        end
    endtask

    task automatic drive_codes(input int count, input int range);
        ffe_adapt_pkg::code_t code;
        for (int n = 0; n < count; n++) begin
            @(negedge clk);
            code = (range >= 128) ? ffe_adapt_pkg::code_t'($random(seed))
                                  : ffe_adapt_pkg::code_t'($random(seed) % range);
            exp_q.push_back(fir_ref());
            for (int i = est_depth - 1; i > 0; i--) begin
                code_model[i] = code_model[i-1];
                eq_model[i]   = eq_model[i-1];
            end
            code_model[0] = code;
            eq_model[0]   = exp_q[exp_q.size()-1];
            code_in       = code;
            code_valid    = 1'b1;
        end
        @(negedge clk);
        code_valid = 1'b0;
        wait_drain();
    endtask

    // The estimator executes two edges after exec rises and then halts.
    task automatic issue_cmd(input logic [2:0] inst);
        @(negedge clk);
        cmd.exec = 1'b0;
        @(negedge clk);
        cmd.exec = 1'b1;
        cmd.inst = inst;
        repeat (2) @(negedge clk);
        case (inst)
            ffe_adapt_pkg::inst_load_init: begin
                for (int i = 0; i < est_depth; i++) begin
                    acc_model[i] = ffe_adapt_pkg::acc_t'(ffe_init[i]) <<< ffe_adapt_pkg::adapt_w;
                end
            end
            ffe_adapt_pkg::inst_shift_left: begin
                for (int i = 0; i < est_depth - 1; i++) begin
                    acc_model[i] = acc_model[i+1];
                end
                acc_model[est_depth-1] = '0;
            end
            ffe_adapt_pkg::inst_shift_right: begin
                for (int i = est_depth - 1; i > 0; i--) begin
                    acc_model[i] = acc_model[i-1];
                end
                acc_model[0] = '0;
            end
            default: ;
        endcase
    endtask

    // One full sweep is followed by a no-operation instruction that freezes the taps again.
    task automatic sweep_taps();
        @(negedge clk);
        cmd.exec = 1'b0;
        cmd.inst = 3'd0;
        repeat (2 * est_depth + 1) @(negedge clk);
        cmd.exec = 1'b1;
        repeat (2) @(negedge clk);
        for (int i = 0; i < est_depth; i++) begin
            acc_model[i] = acc_model[i] + tap_adjust(i) + tap_adjust(i);
        end
    endtask

    task automatic check_taps();
        for (int i = 0; i < est_depth; i++) begin
            n_checks++;
            assert (ffe_est[i] === tap_of(i)) else begin
                $display("[FAIL] ffe_est[%0d]: expected %h, got %h", i, tap_of(i), ffe_est[i]);
                err_count++;
            end
        end
    endtask

    task automatic check_acc();
        for (int i = 0; i < est_depth; i++) begin
            n_checks++;
            assert (uut.u_estimator.acc[i] === acc_model[i]) else begin
                $display("[FAIL] acc[%0d]: expected %h, got %h",
                         i, acc_model[i], uut.u_estimator.acc[i]);
                err_count++;
            end
        end
    endtask

    task automatic report_test(input int num, input string name, input int start_errs);
        int errs;
        errs = err_count - start_errs;
        if (errs == 0) begin
            n_passed++;
            $display("test %0d %s: passed", num, name);
        end else begin
            n_failed++;
            $display("test %0d %s: failed with %0d errors", num, name, errs);
        end
    endtask

    initial begin
        #(watchdog_cycles * clk_period);
        $display("Watchdog expired after %0d cycles", watchdog_cycles);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        rst_n      = 1'b0;
        code_in    = '0;
        code_valid = 1'b0;
        gain       = 1;
        nrz_mode   = 1'b0;
        cmd        = '{exec: 1'b1, inst: 3'd0};
        slicer_cfg = '{bit_target_level: 100, slice_lo: -200, slice_mid: 0, slice_hi: 200};
        for (int i = 0; i < est_depth; i++) begin
            ffe_init[i]   = ffe_adapt_pkg::tap_t'($random(seed) % 41);
            code_model[i] = '0;
            eq_model[i]   = '0;
            acc_model[i]  = '0;
        end
        repeat (reset_cycles) @(negedge clk);
        rst_n = 1'b1;

        mark = err_count;
        repeat (2) @(negedge clk);
        check_taps();
        drive_codes(stream_len, 128);
        report_test(1, "zero taps after reset", mark);

        mark = err_count;
        issue_cmd(ffe_adapt_pkg::inst_load_init);
        check_taps();
        drive_codes(stream_len, 128);
        report_test(2, "load initial taps", mark);

        mark = err_count;
        issue_cmd(ffe_adapt_pkg::inst_shift_left);
        check_taps();
        issue_cmd(ffe_adapt_pkg::inst_shift_right);
        check_taps();
        drive_codes(stream_len, 128);
        report_test(3, "shift taps", mark);

        mark = err_count;
        issue_cmd(ffe_adapt_pkg::inst_load_init);
        sweep_taps();
        check_acc();
        check_taps();
        report_test(4, "PAM4 sweep", mark);

        // Small codes keep every sample inside the wide thresholds.
        mark = err_count;
        slicer_cfg = '{bit_target_level: 150, slice_lo: -400, slice_mid: 0, slice_hi: 400};
        nrz_mode   = 1'b1;
        gain       = 2;
        issue_cmd(ffe_adapt_pkg::inst_load_init);
        drive_codes(2 * est_depth, 32);
        for (int i = 0; i < est_depth; i++) begin
            if (eq_model[i] <= slicer_cfg.slice_lo || eq_model[i] > slicer_cfg.slice_hi) begin
                $display("Sample %0d lies outside the slicer thresholds", i);
                err_count++;
            end
        end
        sweep_taps();
        check_acc();
        check_taps();
        report_test(5, "NRZ sweep", mark);

        $display("%0d tests, %0d passed, %0d failed, %0d checks, %0d errors",
                 n_passed + n_failed, n_passed, n_failed, n_checks, err_count);
        if (err_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule : tb_ffe_adapt
